/* Bender.yml */
package:
  name: taylor_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/taylor_pkg.sv
      - hw/taylor_coef_rom.sv
      - hw/taylor_mac.sv
      - hw/taylor_seq.sv
      - hw/taylor_cfg_regs.sv
      - hw/taylor_unit.sv
  - target: simulation
    include_dirs:
      - hw
      - sim
    files:
      - sim/taylor_unit_tb.sv

/* hw/taylor_cfg_regs.sv */
// Term count and completion counter registers on the Taylor unit register bus
`timescale 1ns/1ps
`include "taylor_defs.svh"

module taylor_cfg_regs
    import taylor_pkg::*;
(
    input  logic            reset,
    input  logic            clk,
    input  logic            reg_valid,
    input  taylor_reg_req_t reg_req,
    output logic [15:0]     reg_rdata,
    input  logic            resp_done,
    output logic [3:0]      n_terms
);

    localparam logic [1:0] addr_terms = 2'd0;
    localparam logic [1:0] addr_done  = 2'd1;

    logic [3:0]  n_q;
    logic [3:0]  n_clamped;
    logic [15:0] done_cnt;
    logic        wr_terms;

    assign wr_terms = reg_valid && reg_req.wr && (reg_req.addr == addr_terms);

    // Keep the count inside the supported range
    always_comb begin
        if (reg_req.wdata < 16'(`TAYLOR_MIN_TERMS))
            n_clamped = 4'(`TAYLOR_MIN_TERMS);
        else if (reg_req.wdata > 16'(`TAYLOR_MAX_TERMS))
            n_clamped = 4'(`TAYLOR_MAX_TERMS);
        else
            n_clamped = reg_req.wdata[3:0];
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            n_q      <= 4'(`TAYLOR_MAX_TERMS);
            done_cnt <= '0;
        end else begin
            if (wr_terms)
                n_q <= n_clamped;
            // Wraps at 16 bits
            if (resp_done)
                done_cnt <= done_cnt + 16'd1;
        end
    end

    // Read data one cycle after the request
    always_ff @(posedge reset) begin
        if (reg_valid && !reg_req.wr) begin
            case (reg_req.addr)
                addr_terms: reg_rdata <= {12'd0, n_q};
                addr_done:  reg_rdata <= done_cnt;
                default:    reg_rdata <= '0;
            endcase
        end
    end

    assign n_terms = n_q;

endmodule

/* hw/taylor_coef_rom.sv */
// Derivative coefficient and reciprocal tables looked up by the Taylor sequencer
`timescale 1ns/1ps
`include "taylor_defs.svh"

module taylor_coef_rom
    import taylor_pkg::*;
(
    input  taylor_func_e                 func,
    input  logic [3:0]                   i,
    input  logic [3:0]                   j,
    output logic signed [`TAYLOR_DW-1:0] coef,
    output logic signed [`TAYLOR_DW-1:0] recip
);

    localparam logic signed [`TAYLOR_DW-1:0] coef_pos = `TAYLOR_ONE;
    localparam logic signed [`TAYLOR_DW-1:0] coef_neg = -coef_pos;

    // f^(i)(0) for each function
    always_comb begin
        coef = '0;
        case (func)
            func_cos: begin
                if (i[1:0] == 2'd0)
                    coef = coef_pos;
                else if (i[1:0] == 2'd2)
                    coef = coef_neg;
            end
            func_sin: begin
                if (i[1:0] == 2'd1)
                    coef = coef_pos;
                else if (i[1:0] == 2'd3)
                    coef = coef_neg;
            end
            func_exp: coef = coef_pos;
            func_cosh: begin
                if (!i[0])
                    coef = coef_pos;
            end
            func_sinh: begin
                if (i[0])
                    coef = coef_pos;
            end
            default: coef = '0;
        endcase
    end

    // 1/j rounded to nearest
    always_comb begin
        case (j)
            4'd1:    recip = 18'h1_0000;
            4'd2:    recip = 18'h0_8000;
            4'd3:    recip = 18'h0_5555;
            4'd4:    recip = 18'h0_4000;
            4'd5:    recip = 18'h0_3333;
            4'd6:    recip = 18'h0_2aab;
            4'd7:    recip = 18'h0_2492;
            4'd8:    recip = 18'h0_2000;
            4'd9:    recip = 18'h0_1c72;
            4'd10:   recip = 18'h0_199a;
            default: recip = '0;
        endcase
    end

endmodule

/* hw/taylor_defs.svh */
// Fixed-point widths and slice operand codes shared by the Taylor unit RTL and testbench
`ifndef TAYLOR_DEFS_SVH
`define TAYLOR_DEFS_SVH

// --------------------------------------------------------------------
// Q2.16 number format
// --------------------------------------------------------------------

// Data word and fraction bits
`define TAYLOR_DW 18
`define TAYLOR_FW 16

// The value 1.0
`define TAYLOR_ONE 18'h1_0000

// Accumulator width of the slice
`define TAYLOR_PW 48

// Term count limits
`define TAYLOR_MIN_TERMS 2
`define TAYLOR_MAX_TERMS 10

// --------------------------------------------------------------------
// Slice operand select codes
// --------------------------------------------------------------------

// X input picks zero or the product
`define TAYLOR_MAC_X_ZERO 1'b0
`define TAYLOR_MAC_X_MULT 1'b1

// Z input picks zero or the previous accumulator
`define TAYLOR_MAC_Z_ZERO 1'b0
`define TAYLOR_MAC_Z_PREV 1'b1

`endif

/* hw/taylor_mac.sv */
// Model of one DSP slice with registered operands used as the shared Taylor MAC
`timescale 1ns/1ps
`include "taylor_defs.svh"

module taylor_mac
    import taylor_pkg::*;
(
    input  logic            reset,
    input  logic            clk,
    input  taylor_mac_in_t  mac_in,
    output taylor_mac_out_t mac_out
);

    logic signed [`TAYLOR_DW-1:0]   a_q;
    logic signed [`TAYLOR_DW-1:0]   b_q;
    logic                           x_sel_q;
    logic                           z_sel_q;
    logic                           x_sel_d;
    logic                           z_sel_d;
    logic signed [2*`TAYLOR_DW-1:0] m_q;
    logic signed [`TAYLOR_PW-1:0]   p_q;
    logic signed [`TAYLOR_PW-1:0]   x_term;
    logic signed [`TAYLOR_PW-1:0]   z_term;

    // Operand registers
    always_ff @(posedge reset) begin
        a_q <= mac_in.a;
        b_q <= mac_in.b;
    end

    // Post-adder inputs with the product sign extended
    assign x_term = (x_sel_d == `TAYLOR_MAC_X_MULT) ? `TAYLOR_PW'(m_q) : '0;
    assign z_term = (z_sel_d == `TAYLOR_MAC_Z_PREV) ? p_q : '0;

    // Selects follow the data through the multiplier stage
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            x_sel_q <= `TAYLOR_MAC_X_ZERO;
            z_sel_q <= `TAYLOR_MAC_Z_ZERO;
            x_sel_d <= `TAYLOR_MAC_X_ZERO;
            z_sel_d <= `TAYLOR_MAC_Z_ZERO;
            m_q     <= '0;
            p_q     <= '0;
        end else begin
            x_sel_q <= mac_in.x_sel;
            z_sel_q <= mac_in.z_sel;
            x_sel_d <= x_sel_q;
            z_sel_d <= z_sel_q;
            m_q     <= a_q * b_q;
            p_q     <= x_term + z_term;
        end
    end

    assign mac_out.m = m_q;
    assign mac_out.p = p_q;

endmodule

/* hw/taylor_pkg.sv */
// Types shared by the Taylor function unit blocks and imported with taylor_pkg::*
`include "taylor_defs.svh"

package taylor_pkg;

    // Codes 5..7 are reserved and evaluate to zero
    typedef enum logic [2:0] {
        func_cos  = 3'd0,
        func_sin  = 3'd1,
        func_exp  = 3'd2,
        func_cosh = 3'd3,
        func_sinh = 3'd4
    } taylor_func_e;

    // Request from the ALU
    typedef struct packed {
        taylor_func_e                 func;
        logic signed [`TAYLOR_DW-1:0] x;
    } taylor_req_t;

    // Result in Q2.16
    typedef struct packed {
        logic signed [`TAYLOR_DW-1:0] result;
    } taylor_resp_t;

    // Slice inputs
    typedef struct packed {
        logic                         x_sel;
        logic                         z_sel;
        logic signed [`TAYLOR_DW-1:0] a;
        logic signed [`TAYLOR_DW-1:0] b;
    } taylor_mac_in_t;

    // Product and accumulator
    typedef struct packed {
        logic signed [2*`TAYLOR_DW-1:0] m;
        logic signed [`TAYLOR_PW-1:0]   p;
    } taylor_mac_out_t;

    // Register bus command
    typedef struct packed {
        logic        wr;
        logic [1:0]  addr;
        logic [15:0] wdata;
    } taylor_reg_req_t;

endpackage

/* hw/taylor_seq.sv */
// Microcoded sequencer that evaluates the Taylor series on the shared MAC slice
`timescale 1ns/1ps
`include "taylor_defs.svh"

module taylor_seq
    import taylor_pkg::*;
(
    input  logic                         reset,
    input  logic                         clk,
    input  logic                         req_valid,
    output logic                         req_ready,
    input  taylor_req_t                  req,
    output logic                         resp_valid,
    input  logic                         resp_ready,
    output taylor_resp_t                 resp,
    output logic                         resp_done,
    input  logic [3:0]                   n_terms,
    output taylor_func_e                 func,
    output logic [3:0]                   idx_i,
    output logic [3:0]                   idx_j,
    input  logic signed [`TAYLOR_DW-1:0] coef,
    input  logic signed [`TAYLOR_DW-1:0] recip,
    output taylor_mac_in_t               mac_in,
    input  taylor_mac_out_t              mac_out
);

    // --------------------------------------------------------------------
    // Micro-operations, one bit each
    // --------------------------------------------------------------------
    localparam logic [14:0] op_nop       = 15'h0000;
    localparam logic [14:0] op_mov_v0_1  = 15'h0001;
    localparam logic [14:0] op_wait_in   = 15'h0002;
    localparam logic [14:0] op_mov_j_1   = 15'h0004;
    localparam logic [14:0] op_repeat_n  = 15'h0008;
    localparam logic [14:0] op_mul_x_rj  = 15'h0010;
    localparam logic [14:0] op_inc_j     = 15'h0020;
    localparam logic [14:0] op_mov_i_0   = 15'h0040;
    localparam logic [14:0] op_mul_chain = 15'h0080;
    localparam logic [14:0] op_mul_acc   = 15'h0100;
    localparam logic [14:0] op_inc_i     = 15'h0200;
    localparam logic [14:0] op_jp_loop   = 15'h0400;
    localparam logic [14:0] op_repeat_2  = 15'h0800;
    localparam logic [14:0] op_mov_res   = 15'h1000;
    localparam logic [14:0] op_wait_out  = 15'h2000;
    localparam logic [14:0] op_jp_1      = 15'h4000;

    logic [3:0]                   pc;
    logic [14:0]                  ops;
    logic [3:0]                   rep_cnt;
    logic [3:0]                   rep_max;
    logic                         rep_hold;
    logic                         stall;
    logic                         accept;
    logic [3:0]                   i_q;
    logic [3:0]                   j_q;
    logic [3:0]                   n_q;
    logic signed [`TAYLOR_DW-1:0] x_q;
    taylor_func_e                 func_q;
    logic signed [`TAYLOR_DW-1:0] val [0:`TAYLOR_MAX_TERMS];
    logic [1:0]                   wb_trig;
    logic [3:0]                   wb_idx [0:1];
    logic signed [`TAYLOR_DW-1:0] m_hi;
    logic signed [`TAYLOR_DW-1:0] p_hi;

    // Program: pass 1 forms x/j, the loop chains powers and accumulates
    always_comb begin
        case (pc)
            4'd0:    ops = op_mov_v0_1;
            4'd1:    ops = op_wait_in | op_mov_j_1;
            4'd2:    ops = op_repeat_n | op_mul_x_rj | op_inc_j;
            4'd3:    ops = op_mov_i_0 | op_mov_j_1;
            4'd4:    ops = op_mul_chain;
            4'd5:    ops = op_mul_acc | op_inc_i | op_inc_j | op_jp_loop;
            4'd6:    ops = op_nop;
            4'd7:    ops = op_mul_acc;
            4'd8:    ops = op_repeat_2;
            4'd9:    ops = op_mov_res;
            4'd10:   ops = op_wait_out | op_jp_1;
            default: ops = op_jp_1;
        endcase
    end

    assign req_ready = |(ops & op_wait_in);
    assign accept    = req_ready && req_valid;
    assign resp_done = resp_valid && resp_ready;

    assign rep_max  = |(ops & op_repeat_n) ? n_q - 4'd1 :
                      |(ops & op_repeat_2) ? 4'd1 : 4'd0;
    assign rep_hold = (rep_cnt != rep_max);
    assign stall    = (accept != req_ready) || rep_hold ||
                      (|(ops & op_wait_out) && !resp_ready);

    // --------------------------------------------------------------------
    // Program counter and repeat counter
    // --------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc      <= '0;
            rep_cnt <= '0;
        end else begin
            if (stall)
                pc <= pc;
            else if (|(ops & op_jp_1))
                pc <= 4'd1;
            else if (|(ops & op_jp_loop) && j_q != n_q - 4'd1)
                pc <= pc - 4'd1;
            else
                pc <= pc + 4'd1;

            if (rep_hold)
                rep_cnt <= rep_cnt + 4'd1;
            else
                rep_cnt <= '0;
        end
    end

    // Index registers and latched term count
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            i_q <= '0;
            j_q <= '0;
            n_q <= 4'(`TAYLOR_MAX_TERMS);
        end else begin
            if (|(ops & op_mov_i_0))
                i_q <= '0;
            else if (|(ops & op_inc_i))
                i_q <= i_q + 4'd1;
            if (|(ops & op_mov_j_1))
                j_q <= 4'd1;
            else if (|(ops & op_inc_j))
                j_q <= j_q + 4'd1;
            if (accept)
                n_q <= n_terms;
        end
    end

    always_ff @(posedge reset) begin
        if (accept) begin
            x_q    <= req.x;
            func_q <= req.func;
        end
    end

    assign func  = func_q;
    assign idx_i = i_q;
    assign idx_j = j_q;

    // --------------------------------------------------------------------
    // Slice operands
    // --------------------------------------------------------------------
    assign m_hi = mac_out.m[`TAYLOR_FW +: `TAYLOR_DW];
    assign p_hi = mac_out.p[`TAYLOR_FW +: `TAYLOR_DW];

    always_comb begin
        mac_in.x_sel = `TAYLOR_MAC_X_ZERO;
        mac_in.z_sel = `TAYLOR_MAC_Z_PREV;
        mac_in.a     = '0;
        mac_in.b     = '0;
        if (|(ops & op_mul_x_rj)) begin
            mac_in.a = x_q;
            mac_in.b = recip;
        end else if (|(ops & op_mul_chain)) begin
            // Previous power comes straight from m after the first step
            mac_in.a = (i_q == 4'd0) ? val[0] : m_hi;
            mac_in.b = val[j_q];
        end else if (|(ops & op_mul_acc)) begin
            mac_in.x_sel = `TAYLOR_MAC_X_MULT;
            mac_in.z_sel = (i_q == 4'd0) ? `TAYLOR_MAC_Z_ZERO : `TAYLOR_MAC_Z_PREV;
            mac_in.a     = val[i_q];
            mac_in.b     = coef;
        end
    end

    // --------------------------------------------------------------------
    // Value array with two-stage write-back
    // --------------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk)
            wb_trig <= '0;
        else
            wb_trig <= {wb_trig[0], |(ops & (op_mul_x_rj | op_mul_chain))};
    end

    always_ff @(posedge reset) begin
        wb_idx[0] <= j_q;
        wb_idx[1] <= wb_idx[0];
        if (|(ops & op_mov_v0_1))
            val[0] <= `TAYLOR_ONE;
        else if (wb_trig[1])
            val[wb_idx[1]] <= m_hi;
    end

    // Response held until the handshake
    always_ff @(posedge reset or posedge clk) begin
        if (clk)
            resp_valid <= 1'b0;
        else if (|(ops & op_mov_res))
            resp_valid <= 1'b1;
        else if (resp_done)
            resp_valid <= 1'b0;
    end

    always_ff @(posedge reset) begin
        if (|(ops & op_mov_res))
            resp.result <= p_hi;
    end

endmodule

/* hw/taylor_unit.sv */
// Top level of the Taylor function unit with request, response and register ports
`timescale 1ns/1ps

module taylor_unit
    import taylor_pkg::*;
(
    input  logic            reset,
    input  logic            clk,
    input  logic            req_valid,
    output logic            req_ready,
    input  taylor_req_t     req,
    output logic            resp_valid,
    input  logic            resp_ready,
    output taylor_resp_t    resp,
    input  logic            reg_valid,
    input  taylor_reg_req_t reg_req,
    output logic [15:0]     reg_rdata
);

    logic [3:0]      n_terms;
    logic            resp_done;
    taylor_func_e    func;
    logic [3:0]      idx_i;
    logic [3:0]      idx_j;
    logic [17:0]     coef;
    logic [17:0]     recip;
    taylor_mac_in_t  mac_in;
    taylor_mac_out_t mac_out;

    taylor_seq u_taylor_seq (
        .reset      (reset),
        .clk        (clk),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .resp_done  (resp_done),
        .n_terms    (n_terms),
        .func       (func),
        .idx_i      (idx_i),
        .idx_j      (idx_j),
        .coef       (coef),
        .recip      (recip),
        .mac_in     (mac_in),
        .mac_out    (mac_out)
    );

    taylor_coef_rom u_taylor_coef_rom (
        .func  (func),
        .i     (idx_i),
        .j     (idx_j),
        .coef  (coef),
        .recip (recip)
    );

    // Shared multiply-accumulate slice
    taylor_mac u_taylor_mac (
        .reset   (reset),
        .clk     (clk),
        .mac_in  (mac_in),
        .mac_out (mac_out)
    );

    taylor_cfg_regs u_taylor_cfg_regs (
        .reset     (reset),
        .clk       (clk),
        .reg_valid (reg_valid),
        .reg_req   (reg_req),
        .reg_rdata (reg_rdata),
        .resp_done (resp_done),
        .n_terms   (n_terms)
    );

endmodule

/* sim/taylor_model.svh */
// Reference model of the Taylor unit arithmetic, included inside the testbench module
`ifndef TAYLOR_MODEL_SVH
`define TAYLOR_MODEL_SVH

`include "taylor_defs.svh"

// Derivative at zero for term i, as +1.0, 0 or -1.0
function automatic logic signed [`TAYLOR_DW-1:0] series_coef(
    input logic [2:0] func,
    input int         i
);
    logic signed [`TAYLOR_DW-1:0] one;
    one = `TAYLOR_ONE;
    case (func)
        3'd0:    return (i % 4 == 0) ? one : (i % 4 == 2) ? -one : 18'sd0;
        3'd1:    return (i % 4 == 1) ? one : (i % 4 == 3) ? -one : 18'sd0;
        3'd2:    return one;
        3'd3:    return (i % 2 == 0) ? one : 18'sd0;
        3'd4:    return (i % 2 == 1) ? one : 18'sd0;
        default: return 18'sd0;
    endcase
endfunction

// Series value for n terms, truncating exactly as the fixed-point datapath does
function automatic logic signed [`TAYLOR_DW-1:0] taylor_model(
    input logic [2:0]                   func,
    input logic signed [`TAYLOR_DW-1:0] x,
    input int                           n
);
    logic signed [`TAYLOR_DW-1:0]   v [0:`TAYLOR_MAX_TERMS];
    logic signed [`TAYLOR_DW-1:0]   t;
    logic signed [`TAYLOR_DW-1:0]   r;
    logic signed [2*`TAYLOR_DW-1:0] prod;
    logic signed [`TAYLOR_PW-1:0]   acc;
    int                             j;
    v[0] = `TAYLOR_ONE;
    // Scaled argument x/j, then the running power x^j/j!
    for (j = 1; j <= n; j++) begin
        r    = 18'((int'(`TAYLOR_ONE) + j / 2) / j);
        prod = x * r;
        t    = prod[`TAYLOR_FW +: `TAYLOR_DW];
        if (j == 1) begin
            v[1] = t;
        end else begin
            prod = v[j-1] * t;
            v[j] = prod[`TAYLOR_FW +: `TAYLOR_DW];
        end
    end
    acc = '0;
    for (j = 0; j < n; j++) begin
        prod = v[j] * series_coef(func, j);
        acc  = acc + prod;
    end
    return acc[`TAYLOR_FW +: `TAYLOR_DW];
endfunction

`endif

/* sim/taylor_unit_tb.sv */
// Testbench for the Taylor function unit, applies a stimulus table and checks against the model
`timescale 1ns/1ps
`include "taylor_defs.svh"

module taylor_unit_tb
    import taylor_pkg::*;
();

    `include "taylor_model.svh"

    // Function code, argument, raw term count written before the request, back-pressure
    typedef struct packed {
        logic [2:0]                   func;
        logic signed [`TAYLOR_DW-1:0] x;
        logic [3:0]                   terms;
        logic                         hold;
    } stim_t;

    localparam int num_stim  = 24;
    localparam int max_stall = 8;

    logic            reset;
    logic            clk;
    logic            req_valid;
    logic            req_ready;
    taylor_req_t     req;
    logic            resp_valid;
    logic            resp_ready;
    taylor_resp_t    resp;
    logic            reg_valid;
    taylor_reg_req_t reg_req;
    logic [15:0]     reg_rdata;

    stim_t       stim [0:num_stim-1];
    int          value_errors  = 0;
    int          other_errors  = 0;
    int          resp_count    = 0;
    int          cycle_cnt     = 0;
    int          timeout_limit = 1000;
    logic [31:0] rng_state     = 32'he431_12a5;

    taylor_unit u_taylor_unit (
        .reset      (reset),
        .clk        (clk),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp       (resp),
        .reg_valid  (reg_valid),
        .reg_req    (reg_req),
        .reg_rdata  (reg_rdata)
    );

    // 4 ns clock on the port named reset
    always #2 reset = ~reset;

    always @(posedge reset) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    function automatic int clamp_terms(input logic [3:0] raw);
        if (raw < `TAYLOR_MIN_TERMS)
            return `TAYLOR_MIN_TERMS;
        if (raw > `TAYLOR_MAX_TERMS)
            return `TAYLOR_MAX_TERMS;
        return int'(raw);
    endfunction

    task automatic check_resp(input string name, input taylor_resp_t expected,
                              input taylor_resp_t actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h actual %h",
                     $time, name, expected.result, actual.result);
            value_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
        @(posedge reset);
        reg_valid <= 1'b1;
        reg_req   <= {1'b1, addr, data};
        @(posedge reset);
        reg_valid <= 1'b0;
    endtask

    // Read data shows up one cycle after the request
    task automatic read_reg(input logic [1:0] addr, output logic [15:0] data);
        @(posedge reset);
        reg_valid <= 1'b1;
        reg_req   <= {1'b0, addr, 16'd0};
        @(posedge reset);
        reg_valid <= 1'b0;
        @(negedge reset);
        data = reg_rdata;
    endtask

    task automatic send_req(input stim_t s, output logic sent);
        int waited;
        waited = 0;
        sent   = 1'b0;
        @(negedge reset);
        while (!req_ready && waited < 16) begin
            @(negedge reset);
            waited++;
        end
        if (!req_ready) begin
            $display("req_ready never rose at t=%0t, request skipped", $time);
            other_errors++;
        end else begin
            @(posedge reset);
            req_valid <= 1'b1;
            req       <= {taylor_func_e'(s.func), s.x};
            if (s.hold)
                resp_ready <= 1'b0;
            @(posedge reset);
            req_valid <= 1'b0;
            sent = 1'b1;
        end
    endtask

    task automatic collect_resp(input taylor_resp_t expected, input logic hold, input int n);
        int           waited;
        int           stall_len;
        waited = 0;
        while (!resp_valid && waited < 6 * n + 40) begin
            @(negedge reset);
            waited++;
        end
        if (!resp_valid) begin
            $display("resp_valid never rose at t=%0t, response lost", $time);
            other_errors++;
            return;
        end
        check_resp("resp", expected, resp);
        if (hold) begin
            rng_state = xorshift32(rng_state);
            stall_len = int'(rng_state % max_stall) + 1;
            repeat (stall_len) begin
                @(negedge reset);
                if (!resp_valid) begin
                    $display("resp_valid dropped at t=%0t while resp_ready was low", $time);
                    other_errors++;
                end
                check_resp("resp (held)", expected, resp);
                if (req_ready) begin
                    $display("req_ready rose at t=%0t while the response was held", $time);
                    other_errors++;
                end
            end
            @(posedge reset);
            resp_ready <= 1'b1;
        end
        @(posedge reset);
        resp_count++;
        @(negedge reset);
        if (resp_valid) begin
            $display("resp_valid still high at t=%0t after the handshake", $time);
            other_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int           k;
        int           n;
        logic         sent;
        logic [3:0]   cur_terms;
        logic [15:0]  rdata;
        taylor_resp_t expected;

        reset      = 1'b0;
        clk        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b1;
        reg_valid  = 1'b0;
        reg_req    = '0;

        // Full series first
        stim[0]  = {func_cos,  18'h0_0000, 4'd10, 1'b0};
        stim[1]  = {func_cos,  18'h0_8000, 4'd10, 1'b1};
        stim[2]  = {func_cos,  18'h3_0000, 4'd10, 1'b0};
        stim[3]  = {func_sin,  18'h1_0000, 4'd10, 1'b0};
        stim[4]  = {func_sin,  18'h3_4000, 4'd10, 1'b0};
        stim[5]  = {func_exp,  18'h0_8000, 4'd10, 1'b0};
        stim[6]  = {func_exp,  18'h3_0000, 4'd10, 1'b1};
        stim[7]  = {func_exp,  18'h1_0000, 4'd10, 1'b0};
        stim[8]  = {func_cosh, 18'h1_8000, 4'd10, 1'b0};
        stim[9]  = {func_cosh, 18'h3_8000, 4'd10, 1'b0};
        stim[10] = {func_sinh, 18'h1_0000, 4'd10, 1'b0};
        stim[11] = {func_sinh, 18'h2_8000, 4'd10, 1'b1};
        stim[12] = {func_sin,  18'h0_0000, 4'd10, 1'b0};
        // Short series, then writes that clamp high and low
        stim[13] = {func_cos,  18'h1_0000, 4'd4,  1'b0};
        stim[14] = {func_exp,  18'h0_4000, 4'd4,  1'b1};
        stim[15] = {func_sinh, 18'h3_0000, 4'd4,  1'b0};
        stim[16] = {func_sin,  18'h1_8000, 4'd15, 1'b1};
        stim[17] = {func_cosh, 18'h1_0000, 4'd15, 1'b0};
        stim[18] = {func_exp,  18'h1_0000, 4'd1,  1'b0};
        stim[19] = {func_cos,  18'h2_8000, 4'd1,  1'b1};
        stim[20] = {func_sinh, 18'h0_8000, 4'd1,  1'b0};
        // Reserved codes
        stim[21] = {3'd5,      18'h1_0000, 4'd10, 1'b0};
        stim[22] = {3'd6,      18'h3_0000, 4'd10, 1'b1};
        stim[23] = {3'd7,      18'h0_8000, 4'd10, 1'b0};

        // Reset and the opening register checks need some slack too
        timeout_limit = 50;
        for (k = 0; k < num_stim; k++)
            timeout_limit += 6 * clamp_terms(stim[k].terms) + 40 + max_stall;

        repeat (4) @(posedge reset);
        clk <= 1'b0;

        @(negedge reset);
        if (resp_valid) begin
            $display("resp_valid high right after reset");
            other_errors++;
        end
        n = 0;
        while (!req_ready && n < 8) begin
            @(negedge reset);
            n++;
        end
        if (!req_ready) begin
            $display("req_ready did not rise within 8 cycles of reset");
            other_errors++;
        end
        read_reg(2'd0, rdata);
        check_word("reg_rdata (terms)", 16'd10, rdata);
        read_reg(2'd1, rdata);
        check_word("reg_rdata (done count)", 16'd0, rdata);

        cur_terms = 4'd10;
        for (k = 0; k < num_stim; k++) begin
            if (stim[k].terms != cur_terms) begin
                write_reg(2'd0, {12'd0, stim[k].terms});
                read_reg(2'd0, rdata);
                check_word("reg_rdata (terms)", 16'(clamp_terms(stim[k].terms)), rdata);
                cur_terms = stim[k].terms;
            end
            n = clamp_terms(stim[k].terms);
            expected.result = taylor_model(stim[k].func, stim[k].x, n);
            send_req(stim[k], sent);
            if (sent)
                collect_resp(expected, stim[k].hold, n);
        end

        read_reg(2'd1, rdata);
        check_word("reg_rdata (done count)", 16'(resp_count), rdata);

        $display("Errors: %0d value mismatches, %0d protocol failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* taylor_unit.f */
+incdir+hw
+incdir+sim
hw/taylor_pkg.sv
hw/taylor_coef_rom.sv
hw/taylor_mac.sv
hw/taylor_seq.sv
hw/taylor_cfg_regs.sv
hw/taylor_unit.sv
sim/taylor_unit_tb.sv
